//--- rtl/pkt_chk_pkg.sv
// Packet header checker package with widths, header layout, bus structs and FSM states
`default_nettype none

package pkt_chk_pkg;

	////////////////////////////////////////////////////////////
	// Memory geometry
	////////////////////////////////////////////////////////////
	localparam int MEM_DEPTH = 32;
	localparam int ADDR_W    = 5;
	localparam int WORD_W    = 32;

	// CRC-8 generator, x^8 + x^2 + x + 1
	localparam logic [7:0] CRC_POLY = 8'h07;

	// Header word bit positions
	localparam int HDR_ECC_LSB  = 0;
	localparam int HDR_CNT_LSB  = 4;
	localparam int HDR_TYPE_LSB = 8;
	localparam int HDR_PAR_BIT  = 12;

	////////////////////////////////////////////////////////////
	// Plain vector types
	////////////////////////////////////////////////////////////
	typedef logic [ADDR_W-1:0] mem_addr_t;
	typedef logic [WORD_W-1:0] mem_word_t;
	typedef logic [3:0]        byte_cnt_t;
	typedef logic [3:0]        pkt_type_t;
	// Hamming code as stored, or syndrome after the check
	typedef logic [3:0]        ecc_code_t;
	typedef logic [7:0]        crc_t;

	// One host load, 37 bits
	typedef struct packed {
		mem_addr_t addr;
		mem_word_t data;
	} mem_wr_t;

	// One check request, header word address only
	typedef struct packed {
		mem_addr_t hdr_addr;
	} chk_job_t;

	// Returned with the job ack, 11 bits
	typedef struct packed {
		logic      ecc_corr;
		logic      ecc_uncorr;
		logic      crc_err;
		pkt_type_t pkt_type;
		byte_cnt_t byte_cnt;
	} chk_result_t;

	// Decoder output, data is {pkt_type, byte_cnt} after correction
	typedef struct packed {
		logic [7:0] data;
		logic       corr;
		logic       uncorr;
	} ecc_out_t;

	// Controller states
	typedef enum logic [2:0] {
		CTRL_IDLE,
		CTRL_HDR_WAIT,
		CTRL_HDR_CHECK,
		CTRL_PAYLOAD,
		CTRL_CRC_CMP,
		CTRL_DONE
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- rtl/pkt_mem.sv
// Packet word memory, four-phase host write port and synchronous read port
`timescale 1ns/1ns
`default_nettype none

module pkt_mem (
	input  logic                   clk,
	input  logic                   reset,
	// Host write side
	input  pkt_chk_pkg::mem_wr_t   load_i,
	input  logic                   load_req_i,
	output logic                   load_ack_o,
	// Checker read side
	input  logic                   rd_en_i,
	input  pkt_chk_pkg::mem_addr_t rd_addr_i,
	output pkt_chk_pkg::mem_word_t rd_data_o
);
	import pkt_chk_pkg::*;

	mem_word_t mem [MEM_DEPTH];
	mem_word_t rd_data_q;
	logic      ack_q;
	logic      wr_fire;

	// Write only on the rising phase, a held req sees ack high
	assign wr_fire = load_req_i && !ack_q;

	////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (wr_fire)
			mem[load_i.addr] <= load_i.data;
		// Data valid the cycle after rd_en
		if (rd_en_i)
			rd_data_q <= mem[rd_addr_i];
	end

	// Load handshake
	// ack rises the cycle after req, falls the cycle after req drops
	always_ff @(posedge clk) begin
		if (reset) begin
			ack_q <= 1'b0;
		end else if (wr_fire) begin
			ack_q <= 1'b1;
		end else if (!load_req_i) begin
			ack_q <= 1'b0;
		end
	end

	assign load_ack_o = ack_q;
	assign rd_data_o  = rd_data_q;

endmodule

`default_nettype wire

//--- rtl/hdr_ecc_decoder.sv
// Header SEC-DED decoder, checks {pkt_type, byte_cnt} and corrects a single-bit error
`timescale 1ns/1ns
`default_nettype none

module hdr_ecc_decoder (
	input  logic [7:0]             data_i,
	input  pkt_chk_pkg::ecc_code_t code_i,
	input  logic                   par_i,
	output pkt_chk_pkg::ecc_out_t  ecc_o
);
	import pkt_chk_pkg::*;

	ecc_code_t  calc_code;
	ecc_code_t  syndrome;
	logic       par_mismatch;
	logic [7:0] flip_mask;

	////////////////////////////////////////////////////////////
	// Recomputed Hamming check bits
	////////////////////////////////////////////////////////////
	assign calc_code[0] = data_i[0] ^ data_i[1] ^ data_i[3] ^ data_i[4] ^ data_i[6];
	assign calc_code[1] = data_i[0] ^ data_i[2] ^ data_i[3] ^ data_i[5] ^ data_i[6];
	assign calc_code[2] = data_i[1] ^ data_i[2] ^ data_i[3] ^ data_i[7];
	assign calc_code[3] = data_i[4] ^ data_i[5] ^ data_i[6] ^ data_i[7];

	assign syndrome = code_i ^ calc_code;

	// Overall parity spans data, code and the parity bit itself
	assign par_mismatch = ^{data_i, code_i, par_i};

	// Syndrome to data bit position
	always_comb begin
		case (syndrome)
			4'b0011: flip_mask = 8'b0000_0001;
			4'b0101: flip_mask = 8'b0000_0010;
			4'b0110: flip_mask = 8'b0000_0100;
			4'b0111: flip_mask = 8'b0000_1000;
			4'b1001: flip_mask = 8'b0001_0000;
			4'b1010: flip_mask = 8'b0010_0000;
			4'b1011: flip_mask = 8'b0100_0000;
			4'b1100: flip_mask = 8'b1000_0000;
			// Code bit or parity bit hit, data is fine
			default: flip_mask = 8'h00;
		endcase
	end

	// Classification
	// odd parity means one flipped bit, even parity with a syndrome means two
	always_comb begin
		ecc_o.data   = par_mismatch ? (data_i ^ flip_mask) : data_i;
		ecc_o.corr   = par_mismatch;
		ecc_o.uncorr = !par_mismatch && (syndrome != 4'b0000);
	end

endmodule

`default_nettype wire

//--- rtl/crc8_accum.sv
// Running CRC-8 accumulator, advances one byte per cycle MSB first
`timescale 1ns/1ns
`default_nettype none

module crc8_accum (
	input  logic              clk,
	input  logic              reset,
	input  logic              clear_i,
	input  logic              byte_valid_i,
	input  pkt_chk_pkg::crc_t byte_i,
	output pkt_chk_pkg::crc_t crc_o
);
	import pkt_chk_pkg::*;

	crc_t crc_q;
	crc_t crc_next;

	////////////////////////////////////////////////////////////
	// Eight shift steps of the byte-wise update
	////////////////////////////////////////////////////////////
	always_comb begin
		// Byte enters at the top, MSB first
		crc_next = crc_q ^ byte_i;
		for (int i = 0; i < 8; i++) begin
			if (crc_next[7])
				crc_next = (crc_next << 1) ^ CRC_POLY;
			else
				crc_next = crc_next << 1;
		end
	end

	// Clear has priority over a byte in the same cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			crc_q <= '0;
		end else if (clear_i) begin
			crc_q <= '0;
		end else if (byte_valid_i) begin
			crc_q <= crc_next;
		end
	end

	assign crc_o = crc_q;

endmodule

`default_nettype wire

//--- rtl/pkt_chk_ctrl.sv
// Checker control FSM, runs the job handshake, sequences memory reads and builds the result
`timescale 1ns/1ns
`default_nettype none

module pkt_chk_ctrl (
	input  logic                     clk,
	input  logic                     reset,
	input  pkt_chk_pkg::chk_job_t    job_i,
	input  logic                     job_req_i,
	output logic                     job_ack_o,
	output pkt_chk_pkg::chk_result_t result_o,
	output logic                     rd_en_o,
	output pkt_chk_pkg::mem_addr_t   rd_addr_o,
	input  pkt_chk_pkg::mem_word_t   rd_data_i,
	output logic [7:0]               ecc_data_o,
	output pkt_chk_pkg::ecc_code_t   ecc_code_o,
	output logic                     ecc_par_o,
	input  pkt_chk_pkg::ecc_out_t    ecc_i,
	output logic                     crc_clear_o,
	output logic                     crc_byte_valid_o,
	output pkt_chk_pkg::crc_t        crc_byte_o,
	input  pkt_chk_pkg::crc_t        crc_i
);
	import pkt_chk_pkg::*;

	ctrl_state_t state_q;
	ctrl_state_t state_d;
	logic        job_ack_q;
	chk_result_t result_q;

	// Flags of the running job
	logic        ecc_corr_q;
	logic        ecc_uncorr_q;
	logic        crc_err_q;

	// Job data
	mem_addr_t   rd_addr_q;
	byte_cnt_t   cnt_q;
	pkt_type_t   pkt_type_q;
	byte_cnt_t   byte_cnt_q;
	crc_t        crc_stored_q;

	logic        job_start;
	logic        hdr_ok;
	logic        pay_active;

	// New job only from idle with the previous ack already dropped
	assign job_start  = (state_q == CTRL_IDLE) && job_req_i && !job_ack_q;
	assign hdr_ok     = !ecc_i.uncorr;
	// Payload bytes still arriving, zero means the CRC word is on the bus
	assign pay_active = (state_q == CTRL_PAYLOAD) && (cnt_q != '0);

	////////////////////////////////////////////////////////////
	// Header fields straight off the read data
	////////////////////////////////////////////////////////////
	assign ecc_data_o = {rd_data_i[HDR_TYPE_LSB +: 4], rd_data_i[HDR_CNT_LSB +: 4]};
	assign ecc_code_o = rd_data_i[HDR_ECC_LSB +: 4];
	assign ecc_par_o  = rd_data_i[HDR_PAR_BIT];

	// Read issue
	// header in HDR_WAIT, first payload word in HDR_CHECK, then one per cycle
	assign rd_en_o   = (state_q == CTRL_HDR_WAIT)
	                || ((state_q == CTRL_HDR_CHECK) && hdr_ok)
	                || pay_active;
	assign rd_addr_o = rd_addr_q;

	// CRC feed, low byte of each returning word
	assign crc_clear_o      = (state_q == CTRL_HDR_CHECK);
	assign crc_byte_valid_o = pay_active;
	assign crc_byte_o       = rd_data_i[7:0];

	assign job_ack_o = job_ack_q;
	assign result_o  = result_q;

	////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////
	always_comb begin
		state_d = state_q;
		case (state_q)
			CTRL_IDLE:      if (job_start) state_d = CTRL_HDR_WAIT;
			CTRL_HDR_WAIT:  state_d = CTRL_HDR_CHECK;
			// Uncorrectable header skips the payload
			CTRL_HDR_CHECK: state_d = hdr_ok ? CTRL_PAYLOAD : CTRL_DONE;
			CTRL_PAYLOAD:   if (cnt_q == '0) state_d = CTRL_CRC_CMP;
			CTRL_CRC_CMP:   state_d = CTRL_DONE;
			// Wait for the host to drop req
			CTRL_DONE:      if (job_ack_q && !job_req_i) state_d = CTRL_IDLE;
			default:        state_d = CTRL_IDLE;
		endcase
	end

	// Control state, flags and handshake
	always_ff @(posedge clk) begin
		if (reset) begin
			state_q      <= CTRL_IDLE;
			job_ack_q    <= 1'b0;
			result_q     <= '0;
			ecc_corr_q   <= 1'b0;
			ecc_uncorr_q <= 1'b0;
			crc_err_q    <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == CTRL_HDR_CHECK) begin
				ecc_corr_q   <= ecc_i.corr;
				ecc_uncorr_q <= ecc_i.uncorr;
				crc_err_q    <= 1'b0;
			end
			if (state_q == CTRL_CRC_CMP)
				crc_err_q <= (crc_i != crc_stored_q);
			if (state_q == CTRL_DONE) begin
				if (!job_ack_q) begin
					// Result frozen here and held while ack is high
					result_q.ecc_corr   <= ecc_corr_q;
					result_q.ecc_uncorr <= ecc_uncorr_q;
					result_q.crc_err    <= crc_err_q;
					result_q.pkt_type   <= pkt_type_q;
					result_q.byte_cnt   <= byte_cnt_q;
					job_ack_q           <= 1'b1;
				end else if (!job_req_i) begin
					job_ack_q <= 1'b0;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Address, countdown and captured header data
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (job_start)
			rd_addr_q <= job_i.hdr_addr;
		else if (rd_en_o)
			rd_addr_q <= rd_addr_q + 1'b1;

		// Corrected fields, count drives the payload length
		if (state_q == CTRL_HDR_CHECK) begin
			pkt_type_q <= ecc_i.data[7:4];
			byte_cnt_q <= ecc_i.data[3:0];
			cnt_q      <= ecc_i.data[3:0];
		end else if (pay_active) begin
			cnt_q <= cnt_q - 1'b1;
		end

		// Word after the last payload byte carries the stored CRC
		if ((state_q == CTRL_PAYLOAD) && (cnt_q == '0))
			crc_stored_q <= rd_data_i[7:0];
	end

endmodule

`default_nettype wire

//--- rtl/pkt_chk_top.sv
// Packet header checker top, joins packet memory, controller, ECC decoder and CRC unit
`timescale 1ns/1ns
`default_nettype none

module pkt_chk_top (
	input  logic                     clk,
	input  logic                     reset,
	// Host load port, four-phase
	input  pkt_chk_pkg::mem_wr_t     load_i,
	input  logic                     load_req_i,
	output logic                     load_ack_o,
	// Host job port, four-phase
	input  pkt_chk_pkg::chk_job_t    job_i,
	input  logic                     job_req_i,
	output logic                     job_ack_o,
	output pkt_chk_pkg::chk_result_t result_o
);
	import pkt_chk_pkg::*;

	// Read port between controller and memory
	logic       rd_en;
	mem_addr_t  rd_addr;
	mem_word_t  rd_data;

	// Header field to the decoder and its verdict
	logic [7:0] ecc_data;
	ecc_code_t  ecc_code;
	logic       ecc_par;
	ecc_out_t   ecc_out;

	// Byte stream into the CRC unit
	logic       crc_clear;
	logic       crc_byte_valid;
	crc_t       crc_byte;
	crc_t       crc_val;

	////////////////////////////////////////////////////////////
	// Packet memory
	////////////////////////////////////////////////////////////
	pkt_mem u_mem (
		.clk        (clk),
		.reset      (reset),
		.load_i     (load_i),
		.load_req_i (load_req_i),
		.load_ack_o (load_ack_o),
		.rd_en_i    (rd_en),
		.rd_addr_i  (rd_addr),
		.rd_data_o  (rd_data)
	);

	////////////////////////////////////////////////////////////
	// Job sequencing
	////////////////////////////////////////////////////////////
	pkt_chk_ctrl u_ctrl (
		.clk              (clk),
		.reset            (reset),
		.job_i            (job_i),
		.job_req_i        (job_req_i),
		.job_ack_o        (job_ack_o),
		.result_o         (result_o),
		.rd_en_o          (rd_en),
		.rd_addr_o        (rd_addr),
		.rd_data_i        (rd_data),
		.ecc_data_o       (ecc_data),
		.ecc_code_o       (ecc_code),
		.ecc_par_o        (ecc_par),
		.ecc_i            (ecc_out),
		.crc_clear_o      (crc_clear),
		.crc_byte_valid_o (crc_byte_valid),
		.crc_byte_o       (crc_byte),
		.crc_i            (crc_val)
	);

	// Header check, purely combinational
	hdr_ecc_decoder u_ecc (
		.data_i (ecc_data),
		.code_i (ecc_code),
		.par_i  (ecc_par),
		.ecc_o  (ecc_out)
	);

	// Payload CRC
	crc8_accum u_crc (
		.clk          (clk),
		.reset        (reset),
		.clear_i      (crc_clear),
		.byte_valid_i (crc_byte_valid),
		.byte_i       (crc_byte),
		.crc_o        (crc_val)
	);

endmodule

`default_nettype wire

//--- verif/pkt_chk_tb_tasks.svh
// Directed tests and handshake drivers for the packet header checker testbench
`ifndef PKT_CHK_TB_TASKS_SVH
`define PKT_CHK_TB_TASKS_SVH

	////////////////////////////////////////////////////////////
	// Handshake drivers
	////////////////////////////////////////////////////////////
	task automatic wait_load_ack(input logic level, input string what);
		int cycles;
		cycles = 0;
		while (load_ack_o !== level) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > WAIT_LIMIT)
				timeout_abort(what);
		end
	endtask

	task automatic wait_job_ack(input logic level, input string what, output int cycles);
		cycles = 0;
		while (job_ack_o !== level) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > WAIT_LIMIT)
				timeout_abort(what);
		end
	endtask

	// Four-phase load of one word
	task automatic load_word(input mem_addr_t addr, input mem_word_t data);
		wait_load_ack(1'b0, "load ack did not drop before a new load");
		load_i.addr = addr;
		load_i.data = data;
		load_req_i  = 1'b1;
		wait_load_ack(1'b1, "load ack did not rise");
		load_req_i  = 1'b0;
		wait_load_ack(1'b0, "load ack did not drop after req fell");
	endtask

	// Four-phase job whose latency counts edges after the sampling edge
	task automatic run_job(input string name, input mem_addr_t addr,
		output chk_result_t res, output int latency);
		int cycles;
		if (job_ack_o !== 1'b0) begin
			$display("Fail %s: job ack before start expected 0 actual %b", name, job_ack_o);
			test_errs++;
		end
		job_i.hdr_addr = addr;
		job_req_i      = 1'b1;
		wait_job_ack(1'b1, "job ack did not rise", cycles);
		latency   = cycles - 1;
		res       = result_o;
		job_req_i = 1'b0;
		wait_job_ack(1'b0, "job ack did not drop after req fell", cycles);
	endtask

	// Writes the payload words and the stored CRC word before the header
	task automatic write_packet(input mem_addr_t addr, input pkt_type_t t, input byte_cnt_t n,
		input logic [12:0] hdr_flip, input crc_t crc_flip);
		mem_word_t w;
		for (int i = 0; i < int'(n); i++) begin
			w          = next_rand();
			payload[i] = w[7:0];
			load_word(addr + mem_addr_t'(i + 1), w);
		end
		w      = next_rand();
		w[7:0] = crc8_ref(int'(n)) ^ crc_flip;
		load_word(addr + mem_addr_t'(int'(n) + 1), w);
		load_word(addr, make_header(t, n) ^ {19'h0, hdr_flip});
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////
	task automatic send_clean_packets();
		chk_result_t res;
		chk_result_t exp;
		pkt_type_t   t;
		mem_addr_t   addr;
		int          lat;
		test_errs = 0;
		if (job_ack_o !== 1'b0 || load_ack_o !== 1'b0) begin
			$display("Fail clean_packets: acks after reset expected 00 actual %b%b",
				job_ack_o, load_ack_o);
			test_errs++;
		end
		if ({result_o.ecc_corr, result_o.ecc_uncorr, result_o.crc_err} !== 3'b000) begin
			$display("Fail clean_packets: flags after reset expected 000 actual %b%b%b",
				result_o.ecc_corr, result_o.ecc_uncorr, result_o.crc_err);
			test_errs++;
		end
		for (int n = 0; n < 16; n++) begin
			t    = pkt_type_t'(next_rand());
			// Both header positions leave room for 15 bytes
			addr = n[0] ? 5'd14 : 5'd0;
			write_packet(addr, t, byte_cnt_t'(n), '0, '0);
			run_job("clean_packets", addr, res, lat);
			exp = {3'b000, t, byte_cnt_t'(n)};
			if (res !== exp) begin
				$display("Fail clean_packets: expected %s actual %s",
					result_str(exp), result_str(res));
				test_errs++;
			end
			if (lat != n + 5) begin
				$display("Fail clean_packets: latency expected %0d actual %0d", n + 5, lat);
				test_errs++;
			end
		end
		finish_test("clean_packets");
	endtask

	task automatic corrupt_stored_crc();
		chk_result_t res;
		chk_result_t exp;
		pkt_type_t   t;
		byte_cnt_t   n;
		crc_t        flip;
		int          lat;
		test_errs = 0;
		for (int k = 0; k < 6; k++) begin
			t    = pkt_type_t'(next_rand());
			n    = byte_cnt_t'(next_rand());
			flip = crc_t'(1) << (next_rand() % 8);
			write_packet(5'd3, t, n, '0, flip);
			run_job("crc_mismatch", 5'd3, res, lat);
			exp = {3'b001, t, n};
			if (res !== exp) begin
				$display("Fail crc_mismatch: expected %s actual %s",
					result_str(exp), result_str(res));
				test_errs++;
			end
			if (lat != int'(n) + 5) begin
				$display("Fail crc_mismatch: latency expected %0d actual %0d", int'(n) + 5, lat);
				test_errs++;
			end
		end
		finish_test("crc_mismatch");
	endtask

	// Bits 0 to 3 of the header hold the code, 4 to 11 the data and 12 the parity
	task automatic flip_one_header_bit();
		chk_result_t res;
		chk_result_t exp;
		pkt_type_t   t;
		byte_cnt_t   n;
		int          lat;
		test_errs = 0;
		for (int b = 0; b < 13; b++) begin
			t = pkt_type_t'(next_rand());
			n = byte_cnt_t'(next_rand());
			write_packet(5'd0, t, n, 13'd1 << b, '0);
			run_job("single_bit", 5'd0, res, lat);
			exp = {3'b100, t, n};
			if (res !== exp) begin
				$display("Fail single_bit: header bit %0d expected %s actual %s",
					b, result_str(exp), result_str(res));
				test_errs++;
			end
			if (lat != int'(n) + 5) begin
				$display("Fail single_bit: latency expected %0d actual %0d", int'(n) + 5, lat);
				test_errs++;
			end
		end
		finish_test("single_bit");
	endtask

	task automatic flip_two_header_bits();
		chk_result_t res;
		pkt_type_t   t;
		byte_cnt_t   n;
		int          b0;
		int          b1;
		int          lat;
		test_errs = 0;
		for (int k = 0; k < 10; k++) begin
			t  = pkt_type_t'(next_rand());
			n  = byte_cnt_t'(next_rand());
			b0 = next_rand() % 13;
			// Second bit always differs from the first
			b1 = (b0 + 1 + next_rand() % 12) % 13;
			write_packet(5'd0, t, n, (13'd1 << b0) | (13'd1 << b1), '0);
			run_job("double_bit", 5'd0, res, lat);
			if (res.ecc_corr !== 1'b0 || res.ecc_uncorr !== 1'b1 || res.crc_err !== 1'b0) begin
				$display("Fail double_bit: bits %0d,%0d %s actual %s",
					b0, b1, "expected corr=0 uncorr=1 crc_err=0", result_str(res));
				test_errs++;
			end
			if (lat != 3) begin
				$display("Fail double_bit: latency expected 3 actual %0d", lat);
				test_errs++;
			end
		end
		finish_test("double_bit");
	endtask

	task automatic hold_job_and_load_req();
		chk_result_t first;
		chk_result_t res;
		chk_result_t exp;
		pkt_type_t   t;
		mem_word_t   crc_word;
		int          cycles;
		int          lat;
		test_errs = 0;
		t = pkt_type_t'(next_rand());
		write_packet(5'd2, t, 4'd3, '0, '0);
		exp = {3'b000, t, 4'd3};
		// Req held high long past a full job
		job_i.hdr_addr = 5'd2;
		job_req_i      = 1'b1;
		wait_job_ack(1'b1, "job ack did not rise with req held", cycles);
		first = result_o;
		if (cycles - 1 != 8) begin
			$display("Fail handshake: held req latency expected 8 actual %0d", cycles - 1);
			test_errs++;
		end
		repeat (12) begin
			@(posedge clk);
			#1;
			if (job_ack_o !== 1'b1 || result_o !== first) begin
				$display("Fail handshake: held expected ack 1 %s actual ack %b %s",
					result_str(first), job_ack_o, result_str(result_o));
				test_errs++;
			end
		end
		job_req_i = 1'b0;
		wait_job_ack(1'b0, "job ack did not drop after req fell", cycles);
		if (first !== exp) begin
			$display("Fail handshake: expected %s actual %s", result_str(exp), result_str(first));
			test_errs++;
		end
		// Data changed under a held load req must not reach memory
		crc_word    = {24'h0, crc8_ref(3)};
		load_i.addr = 5'd6;
		load_i.data = crc_word;
		load_req_i  = 1'b1;
		wait_load_ack(1'b1, "load ack did not rise with req held");
		load_i.data = crc_word ^ 32'h01;
		repeat (4) begin
			@(posedge clk);
			#1;
			if (load_ack_o !== 1'b1) begin
				$display("Fail handshake: held load ack expected 1 actual %b", load_ack_o);
				test_errs++;
			end
		end
		load_req_i = 1'b0;
		wait_load_ack(1'b0, "load ack did not drop after req fell");
		run_job("handshake", 5'd2, res, lat);
		if (res !== exp) begin
			$display("Fail handshake: after held load expected %s actual %s",
				result_str(exp), result_str(res));
			test_errs++;
		end
		// Reload the CRC word with a bad value
		load_word(5'd6, crc_word ^ 32'h80);
		run_job("handshake", 5'd2, res, lat);
		exp = {3'b001, t, 4'd3};
		if (res !== exp) begin
			$display("Fail handshake: after reload expected %s actual %s",
				result_str(exp), result_str(res));
			test_errs++;
		end
		if (lat != 8) begin
			$display("Fail handshake: latency after reload expected 8 actual %0d", lat);
			test_errs++;
		end
		finish_test("handshake");
	endtask

`endif

//--- verif/pkt_chk_tb.sv
// Testbench for the packet header checker with reference models and the directed test sequence
`timescale 1ns/1ns
`default_nettype none

module pkt_chk_tb;
	import pkt_chk_pkg::*;

	localparam int          HALF_PERIOD = 4;
	localparam int          WAIT_LIMIT  = 40;
	localparam logic [31:0] SEED        = 32'h58f9;
	// Start-of-packet value is ignored by the checker
	localparam logic [2:0]  SOP_VAL     = 3'b101;

	logic        clk;
	logic        reset;
	mem_wr_t     load_i;
	logic        load_req_i;
	logic        load_ack_o;
	chk_job_t    job_i;
	logic        job_req_i;
	logic        job_ack_o;
	chk_result_t result_o;

	// Run bookkeeping
	logic [31:0] rng_state;
	logic        timeout_hit;
	int          test_errs;
	int          tests_run;
	int          tests_failed;
	int          total_errs;

	// Payload bytes of the packet written last
	logic [7:0]  payload [16];

	pkt_chk_top u_dut (
		.clk        (clk),
		.reset      (reset),
		.load_i     (load_i),
		.load_req_i (load_req_i),
		.load_ack_o (load_ack_o),
		.job_i      (job_i),
		.job_req_i  (job_req_i),
		.job_ack_o  (job_ack_o),
		.result_o   (result_o)
	);

	always #HALF_PERIOD clk = ~clk;

	////////////////////////////////////////////////////////////
	// Reference models
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// Hamming check bits over {type, count}
	function automatic ecc_code_t ecc_encode(input logic [7:0] d);
		ecc_code_t c;
		c[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6];
		c[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6];
		c[2] = d[1] ^ d[2] ^ d[3] ^ d[7];
		c[3] = d[4] ^ d[5] ^ d[6] ^ d[7];
		return c;
	endfunction

	// Parity bit makes data, code and parity even in total
	function automatic mem_word_t make_header(input pkt_type_t t, input byte_cnt_t n);
		logic [7:0] d;
		ecc_code_t  c;
		logic       p;
		d = {t, n};
		c = ecc_encode(d);
		p = ^{d, c};
		return {16'h0000, SOP_VAL, p, t, n, c};
	endfunction

	// Bitwise CRC-8 over the first n payload bytes with the MSB first
	function automatic crc_t crc8_ref(input int n);
		crc_t crc;
		logic fb;
		crc = '0;
		for (int i = 0; i < n; i++) begin
			for (int b = 7; b >= 0; b--) begin
				fb  = crc[7] ^ payload[i][b];
				crc = {crc[6:0], 1'b0};
				if (fb)
					crc = crc ^ CRC_POLY;
			end
		end
		return crc;
	endfunction

	function automatic string result_str(input chk_result_t r);
		return $sformatf("corr=%0b uncorr=%0b crc_err=%0b type=%h cnt=%h",
			r.ecc_corr, r.ecc_uncorr, r.crc_err, r.pkt_type, r.byte_cnt);
	endfunction

	// Parks the calling process while the watchdog below ends the run
	task automatic timeout_abort(input string what);
		$display("Timeout: %s within %0d cycles", what, WAIT_LIMIT);
		timeout_hit = 1'b1;
		forever @(posedge clk);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		total_errs += test_errs;
		if (test_errs == 0) begin
			$display("Test %s passed", name);
		end else begin
			tests_failed++;
			$display("Test %s failed with %0d errors", name, test_errs);
		end
	endtask

	`include "pkt_chk_tb_tasks.svh"

	initial begin
		wait (timeout_hit);
		$display("=== FAIL ===");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////
	initial begin
		clk          = 1'b0;
		reset        = 1'b1;
		load_i       = '0;
		load_req_i   = 1'b0;
		job_i        = '0;
		job_req_i    = 1'b0;
		rng_state    = SEED;
		timeout_hit  = 1'b0;
		tests_run    = 0;
		tests_failed = 0;
		total_errs   = 0;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		send_clean_packets();
		corrupt_stored_crc();
		flip_one_header_bit();
		flip_two_header_bits();
		hold_job_and_load_req();

		$display("Tests run %0d, failed %0d, failing checks %0d",
			tests_run, tests_failed, total_errs);
		if (total_errs == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- pkt_chk.f
+incdir+verif
rtl/pkt_chk_pkg.sv
rtl/pkt_mem.sv
rtl/hdr_ecc_decoder.sv
rtl/crc8_accum.sv
rtl/pkt_chk_ctrl.sv
rtl/pkt_chk_top.sv
verif/pkt_chk_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the packet checker testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module pkt_chk_tb -f pkt_chk.f \
	--Mdir obj_dir -o pkt_chk_sim > build.log 2>&1 \
	&& ./obj_dir/pkt_chk_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0
